// ==== design/mul_isa_pkg.sv ====
// multiply ISA definitions
// word widths, operand and product word types and the
// M-extension multiply opcode encoding shared by the unit

`default_nettype none

package mul_isa_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	localparam int xlen = 32; // register width of the core

	typedef logic [xlen-1:0]   word_t;  // one operand or result
	typedef logic [2*xlen-1:0] dword_t; // full double-width product

	//////////////////////////////////////////////////////////////////////
	// multiply opcodes
	//////////////////////////////////////////////////////////////////////

	// low half is the same for any signedness, so a single mul_lo
	// high halves differ by how each operand is read
	typedef enum logic [1:0] {
		mul_lo    = 2'b00, // mul, low word of product
		mul_hi_ss = 2'b01, // mulh, signed x signed
		mul_hi_su = 2'b10, // mulhsu, signed rs1 x unsigned rs2
		mul_hi_uu = 2'b11  // mulhu, unsigned x unsigned
	} mul_func_t;

endpackage

`default_nettype wire

// ==== design/mul_fu_pkg.sv ====
// multiply functional unit packets
// issue packet from the scheduler, decoded control, the record that
// walks the partial-product pipeline and the completion packet

`default_nettype none

package mul_fu_pkg;

	import mul_isa_pkg::*;

	localparam int tag_bits = 6; // destination tag width

	typedef logic [tag_bits-1:0] tag_t;

	// one operation as handed over by issue, 72 bits
	typedef struct packed {
		mul_func_t func; // which multiply
		word_t     opa;  // rs1, multiplicand
		word_t     opb;  // rs2, multiplier
		tag_t      tag;  // destination tag
	} mul_issue_t;

	// what travels with the data and is needed at the end
	typedef struct packed {
		logic high_half; // take upper word of product
		tag_t tag;
	} mul_ctrl_t;

	//////////////////////////////////////////////////////////////////////
	// pipeline record, passed stage to stage (200 bits)
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		dword_t    mcand;   // shifted left each stage
		dword_t    mplier;  // shifted right each stage
		dword_t    product; // running partial product
		logic      valid;
		mul_ctrl_t ctrl;
	} mul_stage_t;

	// completion packet, 38 bits
	typedef struct packed {
		word_t value;
		tag_t  tag;
	} mul_result_t;

endpackage

`default_nettype wire

// ==== design/mul_decode.sv ====
// multiply decode
// turns the issue opcode into operand signedness and a half select,
// extends both operands to product width and builds the record
// that enters the first pipeline stage, all combinational

`default_nettype none
`timescale 1ns/10ps

module mul_decode (
	input  logic                   issue_valid,
	input  mul_fu_pkg::mul_issue_t issue,
	output mul_fu_pkg::mul_stage_t first
);

	import mul_isa_pkg::*;
	import mul_fu_pkg::*;

	logic   mcand_signed;  // read rs1 as two's complement
	logic   mplier_signed; // read rs2 as two's complement
	logic   high_half;
	dword_t mcand_ext;
	dword_t mplier_ext;

	// sign rule per opcode
	always_comb begin
		mcand_signed  = 1'b1;
		mplier_signed = 1'b0;
		high_half     = 1'b1;
		unique case (issue.func)
			mul_lo: begin
				mplier_signed = 1'b1; // low word same either way
				high_half     = 1'b0;
			end
			mul_hi_ss: mplier_signed = 1'b1;
			mul_hi_su: mplier_signed = 1'b0; // rs2 unsigned
			mul_hi_uu: mcand_signed  = 1'b0; // both unsigned
			default:   high_half     = 1'b1;
		endcase
	end

	// extend to 64 bits, product of the extended words
	// truncated to 64 is the exact product for each mode
	assign mcand_ext  = mcand_signed ? {{xlen{issue.opa[xlen-1]}}, issue.opa}
	                                 : {{xlen{1'b0}}, issue.opa};
	assign mplier_ext = mplier_signed ? {{xlen{issue.opb[xlen-1]}}, issue.opb}
	                                  : {{xlen{1'b0}}, issue.opb};

	always_comb begin
		first.mcand          = mcand_ext;
		first.mplier         = mplier_ext;
		first.product        = '0; // nothing accumulated yet
		first.valid          = issue_valid;
		first.ctrl.high_half = high_half;
		first.ctrl.tag       = issue.tag;
	end

endmodule

`default_nettype wire

// ==== design/mult_stage.sv ====
// multiply pipeline stage
// multiplies one slice of the multiplier by the multiplicand, adds it
// to the running product, shifts both operands by the slice width
// and registers the record for the next stage

`default_nettype none
`timescale 1ns/10ps

module mult_stage #(
	parameter int num_stages = 4
) (
	input  logic                   clock,
	input  logic                   reset,
	input  mul_fu_pkg::mul_stage_t stage_in,
	output mul_fu_pkg::mul_stage_t stage_out
);

	import mul_isa_pkg::*;
	import mul_fu_pkg::*;

	// multiplier bits consumed per stage
	localparam int slice_bits = (2 * xlen) / num_stages;

	dword_t     slice_prod; // slice x mcand
	mul_stage_t next_stage;

	//////////////////////////////////////////////////////////////////////
	// partial product and operand shift
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		slice_prod = dword_t'(stage_in.mplier[slice_bits-1:0]) * stage_in.mcand;
		next_stage         = stage_in;                    // valid and ctrl ride along
		next_stage.product = stage_in.product + slice_prod;
		next_stage.mplier  = stage_in.mplier >> slice_bits; // next slice to bottom
		next_stage.mcand   = stage_in.mcand << slice_bits;  // weight of next slice
	end

	// payload just flows, valid cleared on reset
	always_ff @(posedge clock) begin
		stage_out <= next_stage;
		if (reset) begin
			stage_out.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/mult_pipe.sv ====
// multiply execute pipeline
// chain of num_stages partial-product stages; the record leaving the
// last stage holds the full 64-bit product with tag and half select
// carried alongside, num_stages cycles after it entered

`default_nettype none
`timescale 1ns/10ps

module mult_pipe #(
	parameter int num_stages = 4
) (
	input  logic                   clock,
	input  logic                   reset,
	input  mul_fu_pkg::mul_stage_t first,
	output mul_fu_pkg::mul_stage_t last
);

	import mul_fu_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// stage chain
	//////////////////////////////////////////////////////////////////////

	// chain[0] is the decoded record, chain[i+1] the output of stage i
	mul_stage_t chain [num_stages+1];

	assign chain[0] = first;

	genvar i;
	generate
		for (i = 0; i < num_stages; i++) begin : g_stage
			mult_stage #(
				.num_stages (num_stages)
			) u_stage (
				.clock     (clock),
				.reset     (reset),
				.stage_in  (chain[i]),
				.stage_out (chain[i+1])
			);
		end
	endgenerate

	// after the last stage the whole multiplier has been consumed,
	// mplier is zero and mcand shifted out, only product matters
	assign last = chain[num_stages];

endmodule

`default_nettype wire

// ==== design/mul_result.sv ====
// multiply result stage
// picks the low or high word of the product, registers it with its
// tag and raises done for one cycle; also counts operations in
// flight from issue to done and reports busy

`default_nettype none
`timescale 1ns/10ps

module mul_result #(
	parameter int num_stages = 4
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    issue_valid,
	input  mul_fu_pkg::mul_stage_t  last,
	output logic                    done,
	output mul_fu_pkg::mul_result_t result,
	output logic                    busy
);

	import mul_isa_pkg::*;
	import mul_fu_pkg::*;

	// up to num_stages + 1 operations outstanding
	localparam int cnt_bits = $clog2(num_stages + 2);

	logic [cnt_bits-1:0] in_flight;
	word_t               pick;

	assign pick = last.ctrl.high_half ? last.product[2*xlen-1:xlen]
	                                  : last.product[xlen-1:0];

	// result payload
	always_ff @(posedge clock) begin
		result.value <= pick;
		result.tag   <= last.ctrl.tag;
	end

	//////////////////////////////////////////////////////////////////////
	// completion strobe and in-flight count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			done      <= 1'b0;
			in_flight <= '0;
		end else begin
			done <= last.valid; // one cycle after leaving the pipe
			case ({issue_valid, done})
				2'b10:   in_flight <= in_flight + 1'b1;
				2'b01:   in_flight <= in_flight - 1'b1;
				default: in_flight <= in_flight; // idle or issue+done together
			endcase
		end
	end

	assign busy = (in_flight != '0);

endmodule

`default_nettype wire

// ==== design/mul_unit.sv ====
// pipelined integer multiply unit
// mul, mulh, mulhsu and mulhu for a 32-bit execute stage; accepts one
// operation per cycle and returns each result with its tag
// num_stages + 1 cycles after issue, in issue order

`default_nettype none
`timescale 1ns/10ps

module mul_unit #(
	parameter int num_stages = 4 // must divide 64
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    issue_valid,
	input  mul_fu_pkg::mul_issue_t  issue,
	output logic                    done,
	output mul_fu_pkg::mul_result_t result,
	output logic                    busy
);

	import mul_fu_pkg::*;

	mul_stage_t first_rec; // decoded, into stage 0
	mul_stage_t last_rec;  // out of final stage

	//////////////////////////////////////////////////////////////////////
	// decode, 0 cycles
	//////////////////////////////////////////////////////////////////////

	mul_decode u_decode (
		.issue_valid (issue_valid),
		.issue       (issue),
		.first       (first_rec)
	);

	//////////////////////////////////////////////////////////////////////
	// execute, num_stages cycles
	//////////////////////////////////////////////////////////////////////

	mult_pipe #(
		.num_stages (num_stages)
	) u_pipe (
		.clock (clock),
		.reset (reset),
		.first (first_rec),
		.last  (last_rec)
	);

	//////////////////////////////////////////////////////////////////////
	// result, 1 cycle
	//////////////////////////////////////////////////////////////////////

	mul_result #(
		.num_stages (num_stages)
	) u_result (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (issue_valid), // in-flight count up
		.last        (last_rec),
		.done        (done),
		.result      (result),
		.busy        (busy)
	);

endmodule

`default_nettype wire

// ==== tests/mul_unit_tb.sv ====
// multiply unit testbench
// replays operations from the pattern file as one-cycle issues with
// random gaps and one back-to-back burst; checks value, tag, latency
// and busy against the file and an outstanding-count model

`timescale 1ns/10ps
`default_nettype none

module mul_unit_tb;

	import mul_isa_pkg::*;
	import mul_fu_pkg::*;

	localparam int num_stages     = 4;
	localparam int n_pat          = 38; // operations in the pattern file
	localparam int n_fields       = 5;  // func opa opb tag expected
	localparam int burst_first    = 12; // this range goes back to back
	localparam int burst_last     = 23;
	localparam int seed           = 2543;
	localparam int timeout_cycles = n_pat * 4 + num_stages + 20;

	logic        clock;
	logic        reset;
	logic        issue_valid;
	mul_issue_t  issue;
	logic        done;
	mul_result_t result;
	logic        busy;

	logic [31:0] pat_mem [n_pat*n_fields]; // flat, n_fields words per op

	int idx_q[$];   // pattern index per outstanding op, oldest first
	int stamp_q[$]; // cycle each op was issued in
	int done_cycle [n_pat];
	int cur_idx     = 0;
	int cycle       = 0;
	int timer       = 0; // cycles since reset release
	int outstanding;     // model of the in-flight count
	int checked     = 0;
	int value_errs  = 0;
	int tag_errs    = 0;
	int timing_errs = 0;
	int busy_errs   = 0;
	int proto_errs  = 0;
	int unsigned seed_out;
	int gap;

	logic [num_stages:0] issue_hist; // issue_valid of the last num_stages+1 cycles

	mul_unit #(
		.num_stages (num_stages)
	) uut (
		.clock       (clock),
		.reset       (reset),
		.issue_valid (issue_valid),
		.issue       (issue),
		.done        (done),
		.result      (result),
		.busy        (busy)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock; // 40 ns period
	end

	function automatic logic [31:0] pattern_field(input int i, input int k);
		return pat_mem[i*n_fields + k];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers, called on falling edges
	//////////////////////////////////////////////////////////////////////

	task automatic drive_issue(input int i);
		logic [31:0] func_word;
		logic [31:0] tag_word;
		func_word   = pattern_field(i, 0);
		tag_word    = pattern_field(i, 3);
		issue_valid = 1'b1;
		issue.func  = mul_func_t'(func_word[1:0]);
		issue.opa   = pattern_field(i, 1);
		issue.opb   = pattern_field(i, 2);
		issue.tag   = tag_word[5:0];
		cur_idx     = i; // picked up by the monitor at the rising edge
	endtask

	// junk operands while idle, must not leak into results
	task automatic idle_issue();
		issue_valid = 1'b0;
		issue.opa   = $urandom;
		issue.opb   = $urandom;
	endtask

	//////////////////////////////////////////////////////////////////////
	// model, sampled on rising edges
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (reset) begin
			issue_hist <= '0;
			timer      <= 0;
		end else begin
			timer <= timer + 1;
			if (issue_valid) begin
				idx_q.push_back(cur_idx);
				stamp_q.push_back(cycle); // issue cycle
			end
			// an op is in flight for num_stages + 1 cycles after its issue
			issue_hist <= {issue_hist[num_stages-1:0], issue_valid};
		end
	end

	assign outstanding = $countones(issue_hist);

	always @(posedge clock) begin
		if (timer >= timeout_cycles) begin
			$display("timeout after %0d cycles past reset with %0d results missing",
			         timer, idx_q.size());
			print_counts();
			$display("TEST FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checking, on falling edges where outputs are settled
	//////////////////////////////////////////////////////////////////////

	task automatic check_result();
		int          idx;
		int          stamp;
		logic [31:0] exp_value;
		logic [31:0] tag_word;
		assert (idx_q.size() != 0) else begin
			proto_errs++;
			$display("done pulsed at cycle %0d with nothing outstanding", cycle);
		end
		if (idx_q.size() == 0) return;
		idx       = idx_q.pop_front(); // oldest issue
		stamp     = stamp_q.pop_front();
		exp_value = pattern_field(idx, 4);
		tag_word  = pattern_field(idx, 3);
		done_cycle[idx] = cycle;
		checked++;
		assert (result.value === exp_value) else begin
			value_errs++;
			$display("[ERROR] result.value pattern %0d: got %h expected %h",
			         idx, result.value, exp_value);
		end
		assert (result.tag === tag_word[5:0]) else begin
			tag_errs++;
			$display("[ERROR] result.tag pattern %0d: got %h expected %h",
			         idx, result.tag, tag_word[5:0]);
		end
		assert (cycle - stamp == num_stages + 1) else begin
			timing_errs++;
			$display("[ERROR] done latency pattern %0d: got %h expected %h",
			         idx, cycle - stamp, num_stages + 1);
		end
	endtask

	always @(negedge clock) begin
		if (timer > 0) begin
			assert (busy === (outstanding != 0)) else begin
				busy_errs++;
				$display("[ERROR] busy at cycle %0d: got %h expected %h",
				         cycle, busy, outstanding != 0);
			end
			if (done === 1'b1) check_result();
		end
	end

	// back-to-back issues must come out one per cycle
	task automatic check_burst();
		for (int i = burst_first + 1; i <= burst_last; i++) begin
			assert (done_cycle[i] == done_cycle[i-1] + 1) else begin
				timing_errs++;
				$display("[ERROR] burst done_cycle pattern %0d: got %h expected %h",
				         i, done_cycle[i], done_cycle[i-1] + 1);
			end
		end
	endtask

	task automatic print_counts();
		$display("errors: value %0d, tag %0d, timing %0d, busy %0d, protocol %0d",
		         value_errs, tag_errs, timing_errs, busy_errs, proto_errs);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed_out    = $urandom(seed); // one seed for the whole run
		reset       = 1'b1;
		issue_valid = 1'b0;
		issue       = '0;
		gap         = 0;
		for (int i = 0; i < n_pat; i++) done_cycle[i] = -1;
		$readmemh("tests/mul_patterns.txt", pat_mem);
		assert (!$isunknown(pattern_field(n_pat - 1, 4))) else begin
			proto_errs++;
			$display("pattern file did not supply all %0d operations", n_pat);
		end

		repeat (10) @(negedge clock);
		reset = 1'b0;
		repeat (2) @(negedge clock);
		assert (done === 1'b0 && busy === 1'b0) else begin
			proto_errs++;
			$display("done or busy raised after reset with no issue");
		end

		for (int i = 0; i < n_pat; i++) begin
			drive_issue(i);
			@(negedge clock);
			if (i >= burst_first && i < burst_last)
				gap = 0; // keep the burst tight
			else
				gap = $urandom % 4;
			if (gap > 0) begin
				idle_issue();
				repeat (gap) @(negedge clock);
			end
		end
		idle_issue();

		// drain, timeout covers a stuck unit
		while (idx_q.size() != 0 || outstanding != 0) @(negedge clock);
		repeat (3) @(negedge clock); // room for stray done pulses

		check_burst();
		assert (checked == n_pat && idx_q.size() == 0) else begin
			proto_errs++;
			$display("%0d of %0d results seen, %0d left in queue",
			         checked, n_pat, idx_q.size());
		end
		assert (busy === 1'b0) else begin
			busy_errs++;
			$display("[ERROR] busy at end: got %h expected %h", busy, 1'b0);
		end

		print_counts();
		if (value_errs + tag_errs + timing_errs + busy_errs + proto_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/mul_patterns.txt ====
// columns: func opa opb tag expected, all hex
// func: 0 mul, 1 mulh, 2 mulhsu, 3 mulhu
0 00000000 00000000 00 00000000
0 00000001 ffffffff 01 ffffffff
0 ffffffff ffffffff 02 00000001
0 80000000 ffffffff 03 80000000
0 7fffffff 7fffffff 04 00000001
0 80000000 80000000 05 00000000
0 00001234 00005678 06 06260060
0 12345678 00000010 07 23456780
1 00000000 00000000 08 00000000
1 ffffffff ffffffff 09 00000000
1 80000000 80000000 0a 40000000
1 80000000 7fffffff 0b c0000000
1 7fffffff 7fffffff 0c 3fffffff
1 ffffffff 00000001 0d ffffffff
1 80000000 ffffffff 0e 00000000
1 00010000 00010000 0f 00000001
1 fffe0000 00010000 10 fffffffe
2 ffffffff ffffffff 11 ffffffff
2 80000000 ffffffff 12 80000000
2 7fffffff ffffffff 13 7ffffffe
2 00000001 80000000 14 00000000
2 ffffffff 00000001 15 ffffffff
2 80000000 80000000 16 c0000000
2 00000000 ffffffff 17 00000000
2 fffe0000 00010000 18 fffffffe
3 ffffffff ffffffff 19 fffffffe
3 80000000 80000000 1a 40000000
3 80000000 ffffffff 1b 7fffffff
3 7fffffff 7fffffff 1c 3fffffff
3 00000001 ffffffff 1d 00000000
3 00000000 80000000 1e 00000000
3 00010000 00010000 1f 00000001
3 12345678 00000010 20 00000001
0 00000007 fffffffd 21 ffffffeb
1 00000007 fffffffd 22 ffffffff
3 00000007 fffffffd 23 00000006
2 fffffffd 00000007 24 ffffffff
2 00000007 fffffffd 25 00000006

// ==== verilog.f ====
design/mul_isa_pkg.sv
design/mul_fu_pkg.sv
design/mul_decode.sv
design/mult_stage.sv
design/mult_pipe.sv
design/mul_result.sv
design/mul_unit.sv
tests/mul_unit_tb.sv

// ==== Makefile ====
# Verilator build and run for the multiply unit testbench
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= mul_unit_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

BIN := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
